//--- tb.f
+incdir+.
cam_pkg.sv
frame_ram.sv
buf_arbiter.sv
pixel_capture.sv
gray_pass.sv
edge_pass.sv
vga_scan.sv
cam_top.sv
tb_cam_top.sv

//--- tb_cam_top.sv
// ###################################################################
// Testbench for the camera path: capture, gray and edge passes, display
// ###################################################################
`timescale 1ns/1ps
`include "cam_defines.svh"

module tb_cam_top;
    localparam int W         = `CAM_FRAME_W;
    localparam int H         = `CAM_FRAME_H;
    localparam int NPIX      = W * H;
    localparam int FRAME_CYC = `CAM_H_TOTAL * `CAM_V_TOTAL;
    localparam int CLK_NS    = 100;
    // Longest test runs two full processing passes, about 40 raster frames
    localparam int WATCHDOG_NS = 6 * 32 * FRAME_CYC * CLK_NS;
    localparam int PROC_LIMIT  = 24 * FRAME_CYC;
    localparam int GRAB_LIMIT  = 3 * FRAME_CYC;

    logic            clk_25_vga;
    logic            reset_global;
    logic            edge_mode;
    logic            frame_start;
    logic            pix_valid;
    cam_pkg::pixel_t pix_data;
    logic            pix_ready;
    logic            hsync;
    logic            vsync;
    logic            active;
    logic [3:0]      red;
    logic [3:0]      green;
    logic [3:0]      blue;
    logic            proc_done;

    cam_pkg::pixel_t frame_in   [NPIX];
    cam_pkg::pixel_t expect_pix [NPIX];
    cam_pkg::pixel_t shown      [NPIX];
    integer seed;
    int     err_count;
    int     check_count;
    int     test_count;
    int     err_start;

    cam_top u_cam_top (
        .clk_25_vga(clk_25_vga), .reset_global(reset_global), .edge_mode(edge_mode),
        .frame_start(frame_start), .pix_valid(pix_valid), .pix_data(pix_data),
        .pix_ready(pix_ready), .hsync(hsync), .vsync(vsync), .active(active),
        .red(red), .green(green), .blue(blue), .proc_done(proc_done)
    );

    initial begin
        clk_25_vga = 1'b0;
        forever #(CLK_NS / 2) clk_25_vga = ~clk_25_vga;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, a test never finished", $time);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic compare_pixel(input string name, input cam_pkg::pixel_t got,
                                 input cam_pkg::pixel_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        err_count++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, err_count - err_start);
        err_start = err_count;
    endtask

    // (r + 2g + b) / 4 with truncation
    function automatic cam_pkg::gray_t gray_rule(input cam_pkg::pixel_t p);
        int sum;
        sum = p[11:8] + 2 * p[7:4] + p[3:0];
        return cam_pkg::gray_t'(sum / 4);
    endfunction

    function automatic cam_pkg::gray_t edge_rule(input int c, input int r, input int d);
        int dr;
        int dd;
        int s;
        dr = (c > r) ? c - r : r - c;
        dd = (c > d) ? c - d : d - c;
        s  = dr + dd;
        return cam_pkg::gray_t'((s > 15) ? 15 : s);
    endfunction

    function automatic void expect_normal();
        int i;
        for (i = 0; i < NPIX; i++) begin
            expect_pix[i] = frame_in[i];
        end
    endfunction

    // Edge image of the gray image, zero on the last row and column
    function automatic void expect_processed();
        cam_pkg::gray_t g [NPIX];
        cam_pkg::gray_t e;
        int i;
        for (i = 0; i < NPIX; i++) begin
            g[i] = gray_rule(frame_in[i]);
        end
        for (i = 0; i < NPIX; i++) begin
            if ((i / W == H - 1) || (i % W == W - 1)) begin
                expect_pix[i] = '0;
            end else begin
                e = edge_rule(g[i], g[i + 1], g[i + W]);
                expect_pix[i] = {e, e, e};
            end
        end
    endfunction

    task automatic fill_ramp(input int offset);
        int i;
        for (i = 0; i < NPIX; i++) begin
            frame_in[i] = cam_pkg::pixel_t'(i * 21 + offset);
        end
    endtask

    // Blocks of full blue over colour gradients give strong and weak edges
    task automatic fill_pattern(input int variant);
        int i;
        int row;
        int col;
        logic [3:0] rn;
        logic [3:0] gn;
        logic [3:0] bn;
        for (i = 0; i < NPIX; i++) begin
            row = i / W;
            col = i % W;
            rn  = col * 5 + variant;
            gn  = row * 3 + col;
            bn  = (((row / 3) + (col / 4) + variant) % 2 == 1) ? 4'hf : 4'h0;
            frame_in[i] = {rn, gn, bn};
        end
    endtask

    task automatic fill_random();
        int i;
        for (i = 0; i < NPIX; i++) begin
            frame_in[i] = cam_pkg::pixel_t'($random(seed));
        end
    endtask

    task automatic set_edge_mode(input logic value);
        @(posedge clk_25_vga);
        edge_mode <= value;
    endtask

    task automatic send_frame(input bit with_gaps);
        int idx;
        bit gap;
        idx = 0;
        while (idx < NPIX) begin
            gap = with_gaps && (($random(seed) & 3) == 0);
            @(posedge clk_25_vga);
            pix_valid   <= !gap;
            pix_data    <= frame_in[idx];
            frame_start <= (idx == 0) && !gap;
            // Beat is taken at the next edge if ready is high now
            @(negedge clk_25_vga);
            if (!gap && pix_ready) begin
                idx++;
            end
        end
        @(posedge clk_25_vga);
        pix_valid   <= 1'b0;
        frame_start <= 1'b0;
    endtask

    task automatic wait_proc_done(input logic level);
        int guard;
        guard = 0;
        @(negedge clk_25_vga);
        while (proc_done !== level && guard < PROC_LIMIT) begin
            @(negedge clk_25_vga);
            guard++;
        end
        if (proc_done !== level) begin
            report_failure($sformatf("proc_done never went to %0b", level));
        end
    endtask

    // Records one displayed frame in raster order after vsync falls
    task automatic grab_display();
        int   n;
        int   guard;
        logic vs_prev;
        bit   found;
        n     = 0;
        guard = 0;
        found = 1'b0;
        @(negedge clk_25_vga);
        vs_prev = vsync;
        while (!found && guard < GRAB_LIMIT) begin
            @(negedge clk_25_vga);
            found   = vs_prev && !vsync;
            vs_prev = vsync;
            guard++;
        end
        while (found && n < NPIX && guard < GRAB_LIMIT) begin
            @(negedge clk_25_vga);
            if (active) begin
                shown[n] = {red, green, blue};
                n++;
            end else begin
                compare_pixel("blanked rgb", {red, green, blue}, '0);
            end
            guard++;
        end
        if (!found) begin
            report_failure("no vsync falling edge seen");
        end else if (n < NPIX) begin
            report_failure($sformatf("display gave only %0d active pixels", n));
        end
    endtask

    task automatic check_frame(input string label);
        int i;
        for (i = 0; i < NPIX; i++) begin
            compare_pixel($sformatf("%s pixel %0d", label, i), shown[i], expect_pix[i]);
        end
    endtask

    task automatic test_reset_state();
        @(posedge clk_25_vga);
        @(negedge clk_25_vga);
        compare_bit("proc_done", proc_done, 1'b0);
        compare_bit("pix_ready", pix_ready, 1'b1);
        compare_bit("hsync", hsync, 1'b1);
        compare_bit("vsync", vsync, 1'b1);
        compare_bit("active", active, 1'b0);
        compare_pixel("rgb", {red, green, blue}, '0);
        @(posedge clk_25_vga);
        reset_global <= 1'b0;
        report_test("reset state");
    endtask

    task automatic test_normal_video();
        set_edge_mode(1'b0);
        fill_ramp(0);
        expect_normal();
        send_frame(1'b0);
        grab_display();
        check_frame("normal");
        report_test("normal video");
    endtask

    task automatic test_processed();
        set_edge_mode(1'b1);
        fill_pattern(0);
        expect_processed();
        send_frame(1'b0);
        wait_proc_done(1'b1);
        grab_display();
        check_frame("edge");
        report_test("processed mode");
    endtask

    task automatic test_back_pressure();
        set_edge_mode(1'b0);
        wait_proc_done(1'b0);
        fill_pattern(3);
        expect_normal();
        send_frame(1'b1);
        grab_display();
        check_frame("gapped");
        report_test("stream back-pressure");
    endtask

    task automatic test_ignored_frame();
        set_edge_mode(1'b1);
        fill_pattern(5);
        expect_processed();
        send_frame(1'b0);
        // Second frame arrives while the gray pass runs
        fill_ramp(77);
        send_frame(1'b0);
        wait_proc_done(1'b1);
        grab_display();
        check_frame("kept");
        fill_pattern(9);
        expect_processed();
        send_frame(1'b0);
        wait_proc_done(1'b0);
        wait_proc_done(1'b1);
        grab_display();
        check_frame("restart");
        report_test("ignored frame");
    endtask

    task automatic test_random_frame();
        fill_random();
        expect_processed();
        send_frame(1'b0);
        wait_proc_done(1'b0);
        wait_proc_done(1'b1);
        grab_display();
        check_frame("random edge");
        set_edge_mode(1'b0);
        wait_proc_done(1'b0);
        fill_random();
        expect_normal();
        send_frame(1'b0);
        grab_display();
        check_frame("random normal");
        report_test("random frame");
    endtask

    initial begin
        seed         = 32'hefbe;
        err_count    = 0;
        check_count  = 0;
        test_count   = 0;
        err_start    = 0;
        reset_global = 1'b1;
        edge_mode    = 1'b0;
        frame_start  = 1'b0;
        pix_valid    = 1'b0;
        pix_data     = '0;
        test_reset_state();
        test_normal_video();
        test_processed();
        test_back_pressure();
        test_ignored_frame();
        test_random_frame();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- cam_top.sv
// ###################################################################
// Camera top: mode sequencer, frame buffers, passes and display
// ###################################################################
`timescale 1ns/1ps
`include "cam_defines.svh"

module cam_top (
    input  logic            clk_25_vga,
    input  logic            reset_global,
    input  logic            edge_mode,
    input  logic            frame_start,
    input  logic            pix_valid,
    input  cam_pkg::pixel_t pix_data,
    output logic            pix_ready,
    output logic            hsync,
    output logic            vsync,
    output logic            active,
    output logic [3:0]      red,
    output logic [3:0]      green,
    output logic [3:0]      blue,
    output logic            proc_done
);
    cam_pkg::cam_state_t state;
    logic capture_en, frame_end;
    logic gray_start, gray_done, edge_start, edge_done;
    logic cap_req, cap_we, cap_ack;
    logic gray_req, gray_we, gray_ack;
    logic edge_req, edge_ack;
    logic b1_we, b2_we;
    cam_pkg::pix_addr_t cap_addr, gray_addr, edge_addr, b1_addr, b2_addr, disp_addr;
    cam_pkg::pixel_t cap_wdata, gray_wdata, arb_rdata, b1_wdata, b1_rdata;
    cam_pkg::pixel_t b2_wdata, b1_disp, b2_disp, disp_pix;

    // Gray and edge runs each use a start/done four-phase handshake
    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            state      <= cam_pkg::NORMAL;
            gray_start <= 1'b0;
            edge_start <= 1'b0;
        end else begin
            case (state)
                cam_pkg::NORMAL: begin
                    if (frame_end && edge_mode) begin
                        state      <= cam_pkg::GRAY;
                        gray_start <= 1'b1;
                    end
                end
                cam_pkg::GRAY: begin
                    if (gray_done) begin
                        gray_start <= 1'b0;
                    end else if (!gray_start) begin
                        state      <= cam_pkg::EDGE;
                        edge_start <= 1'b1;
                    end
                end
                cam_pkg::EDGE: begin
                    if (edge_done) begin
                        edge_start <= 1'b0;
                    end else if (!edge_start) begin
                        state <= cam_pkg::SHOW;
                    end
                end
                default: begin
                    if (!edge_mode) begin
                        state <= cam_pkg::NORMAL;
                    end else if (frame_end) begin
                        state      <= cam_pkg::GRAY;
                        gray_start <= 1'b1;
                    end
                end
            endcase
        end
    end

    assign capture_en = (state == cam_pkg::NORMAL) || (state == cam_pkg::SHOW);
    assign proc_done  = (state == cam_pkg::SHOW);
    // Live frame in NORMAL, edge result otherwise
    assign disp_pix   = (state == cam_pkg::NORMAL) ? b1_disp : b2_disp;

    pixel_capture u_capture (
        .clk_25_vga(clk_25_vga), .reset_global(reset_global), .capture_en(capture_en),
        .frame_start(frame_start), .pix_valid(pix_valid), .pix_data(pix_data),
        .pix_ready(pix_ready), .req(cap_req), .we(cap_we), .addr(cap_addr),
        .wdata(cap_wdata), .ack(cap_ack), .frame_end(frame_end)
    );

    gray_pass u_gray (
        .clk_25_vga(clk_25_vga), .reset_global(reset_global), .start(gray_start),
        .done(gray_done), .req(gray_req), .we(gray_we), .addr(gray_addr),
        .wdata(gray_wdata), .ack(gray_ack), .rdata(arb_rdata)
    );

    edge_pass u_edge (
        .clk_25_vga(clk_25_vga), .reset_global(reset_global), .start(edge_start),
        .done(edge_done), .req(edge_req), .addr(edge_addr), .ack(edge_ack),
        .rdata(arb_rdata), .out_we(b2_we), .out_addr(b2_addr), .out_wdata(b2_wdata)
    );

    buf_arbiter u_arbiter (
        .clk_25_vga(clk_25_vga), .reset_global(reset_global),
        .cap_req(cap_req), .cap_we(cap_we), .cap_addr(cap_addr),
        .cap_wdata(cap_wdata), .cap_ack(cap_ack),
        .gray_req(gray_req), .gray_we(gray_we), .gray_addr(gray_addr),
        .gray_wdata(gray_wdata), .gray_ack(gray_ack),
        .edge_req(edge_req), .edge_addr(edge_addr), .edge_ack(edge_ack),
        .rdata(arb_rdata), .ram_we(b1_we), .ram_addr(b1_addr),
        .ram_wdata(b1_wdata), .ram_rdata(b1_rdata)
    );

    frame_ram u_buf1 (
        .clk_25_vga(clk_25_vga), .a_we(b1_we), .a_addr(b1_addr), .a_wdata(b1_wdata),
        .a_rdata(b1_rdata), .b_addr(disp_addr), .b_rdata(b1_disp)
    );

    // Buffer two is written only by the edge pass
    frame_ram u_buf2 (
        .clk_25_vga(clk_25_vga), .a_we(b2_we), .a_addr(b2_addr), .a_wdata(b2_wdata),
        .a_rdata(), .b_addr(disp_addr), .b_rdata(b2_disp)
    );

    vga_scan u_scan (
        .clk_25_vga(clk_25_vga), .reset_global(reset_global), .pix_in(disp_pix),
        .rd_addr(disp_addr), .hsync(hsync), .vsync(vsync), .active(active),
        .red(red), .green(green), .blue(blue)
    );

endmodule

//--- vga_scan.sv
// ###################################################################
// Raster scanner: syncs, active flag, display address, blanked colour
// ###################################################################
`timescale 1ns/1ps
`include "cam_defines.svh"

module vga_scan (
    input  logic               clk_25_vga,
    input  logic               reset_global,
    input  cam_pkg::pixel_t    pix_in,
    output cam_pkg::pix_addr_t rd_addr,
    output logic               hsync,
    output logic               vsync,
    output logic               active,
    output logic [3:0]         red,
    output logic [3:0]         green,
    output logic [3:0]         blue
);
    logic [$clog2(`CAM_H_TOTAL)-1:0] h_cnt;
    logic [$clog2(`CAM_V_TOTAL)-1:0] v_cnt;
    logic active_c;

    assign active_c = (h_cnt < `CAM_FRAME_W) && (v_cnt < `CAM_FRAME_H);

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == `CAM_H_TOTAL - 1) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == `CAM_V_TOTAL - 1) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Linear read address inside the active area
    assign rd_addr = active_c ? cam_pkg::pix_addr_t'(v_cnt * `CAM_FRAME_W + h_cnt) : '0;

    // One stage of delay to line up with the RAM read
    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            active <= 1'b0;
        end else begin
            hsync  <= !((h_cnt >= `CAM_HSYNC_START) && (h_cnt <= `CAM_HSYNC_END));
            vsync  <= !((v_cnt >= `CAM_VSYNC_START) && (v_cnt <= `CAM_VSYNC_END));
            active <= active_c;
        end
    end

    assign red   = active ? pix_in[11:8] : 4'h0;
    assign green = active ? pix_in[7:4] : 4'h0;
    assign blue  = active ? pix_in[3:0] : 4'h0;

endmodule

//--- edge_pass.sv
// ###################################################################
// Edge pass: two-neighbour gradient of buffer one into buffer two
// ###################################################################
`timescale 1ns/1ps
`include "cam_defines.svh"

module edge_pass (
    input  logic               clk_25_vga,
    input  logic               reset_global,
    input  logic               start,
    output logic               done,
    output logic               req,
    output cam_pkg::pix_addr_t addr,
    input  logic               ack,
    input  cam_pkg::pixel_t    rdata,
    output logic               out_we,
    output cam_pkg::pix_addr_t out_addr,
    output cam_pkg::pixel_t    out_wdata
);
    localparam int W    = `CAM_FRAME_W;
    localparam int H    = `CAM_FRAME_H;
    localparam int LAST = W * H - 1;

    typedef enum logic [2:0] {IDLE, SETUP, XFER, REL, WRITE, FIN} edge_state_t;

    edge_state_t        state;
    cam_pkg::pix_addr_t pos;
    logic [$clog2(W)-1:0] col;
    logic [$clog2(H)-1:0] row;
    // Read index: 0 centre, 1 right, 2 lower
    logic [1:0]         k;
    cam_pkg::gray_t     g_c;
    cam_pkg::gray_t     g_r;
    cam_pkg::gray_t     g_d;
    cam_pkg::gray_t     d_r;
    cam_pkg::gray_t     d_d;
    cam_pkg::gray_t     edge_val;
    logic [4:0]         diff_sum;
    logic               border;

    assign border   = (col == W - 1) || (row == H - 1);
    assign d_r      = (g_c > g_r) ? g_c - g_r : g_r - g_c;
    assign d_d      = (g_c > g_d) ? g_c - g_d : g_d - g_c;
    assign diff_sum = d_r + d_d;
    // Saturate at full scale
    assign edge_val = diff_sum[4] ? 4'hF : diff_sum[3:0];

    assign out_we    = (state == WRITE);
    assign out_addr  = pos;
    assign out_wdata = border ? '0 : {edge_val, edge_val, edge_val};

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            state <= IDLE;
            req   <= 1'b0;
            addr  <= '0;
            done  <= 1'b0;
            pos   <= '0;
            col   <= '0;
            row   <= '0;
            k     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        pos   <= '0;
                        col   <= '0;
                        row   <= '0;
                        state <= SETUP;
                    end
                end
                // Border pixels skip the reads and write zero
                SETUP: begin
                    if (border) begin
                        state <= WRITE;
                    end else begin
                        addr  <= pos;
                        k     <= '0;
                        req   <= 1'b1;
                        state <= XFER;
                    end
                end
                XFER: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= REL;
                    end
                end
                REL: begin
                    if (!ack) begin
                        if (k == 2'd2) begin
                            state <= WRITE;
                        end else begin
                            k     <= k + 1'b1;
                            addr  <= (k == 2'd0) ? pos + 1'b1
                                                 : pos + cam_pkg::pix_addr_t'(W);
                            req   <= 1'b1;
                            state <= XFER;
                        end
                    end
                end
                WRITE: begin
                    if (pos == cam_pkg::pix_addr_t'(LAST)) begin
                        done  <= 1'b1;
                        state <= FIN;
                    end else begin
                        pos <= pos + 1'b1;
                        if (col == W - 1) begin
                            col <= '0;
                            row <= row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                        state <= SETUP;
                    end
                end
                default: begin
                    if (!start) begin
                        done  <= 1'b0;
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Buffer one holds gray pixels, so the low nibble is the intensity
    always_ff @(posedge clk_25_vga) begin
        if (state == XFER && ack) begin
            case (k)
                2'd0:    g_c <= rdata[3:0];
                2'd1:    g_r <= rdata[3:0];
                default: g_d <= rdata[3:0];
            endcase
        end
    end

    // Written address stays in the frame and agrees with the border row and column
    a_out_in_frame: assert property (@(posedge clk_25_vga) disable iff (reset_global)
        out_we |-> (out_addr <= cam_pkg::pix_addr_t'(LAST))
                   && (out_addr == cam_pkg::pix_addr_t'(row * W + col)));

endmodule

//--- gray_pass.sv
// ###################################################################
// Grayscale pass: read, convert and write back every buffer one pixel
// ###################################################################
`timescale 1ns/1ps
`include "cam_defines.svh"

module gray_pass (
    input  logic               clk_25_vga,
    input  logic               reset_global,
    input  logic               start,
    output logic               done,
    output logic               req,
    output logic               we,
    output cam_pkg::pix_addr_t addr,
    output cam_pkg::pixel_t    wdata,
    input  logic               ack,
    input  cam_pkg::pixel_t    rdata
);
    localparam int LAST = `CAM_FRAME_W * `CAM_FRAME_H - 1;

    typedef enum logic [1:0] {IDLE, XFER, REL, FIN} gray_state_t;

    gray_state_t    state;
    logic [5:0]     luma_sum;
    cam_pkg::gray_t gray_val;

    // (r + 2g + b) / 4, truncated
    assign luma_sum = rdata[11:8] + {rdata[7:4], 1'b0} + rdata[3:0];
    assign gray_val = luma_sum[5:2];

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            state <= IDLE;
            req   <= 1'b0;
            we    <= 1'b0;
            addr  <= '0;
            done  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        addr  <= '0;
                        we    <= 1'b0;
                        req   <= 1'b1;
                        state <= XFER;
                    end
                end
                XFER: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= REL;
                    end
                end
                // After a read comes the write-back, after a write the next pixel
                REL: begin
                    if (!ack) begin
                        if (!we) begin
                            we    <= 1'b1;
                            req   <= 1'b1;
                            state <= XFER;
                        end else if (addr == cam_pkg::pix_addr_t'(LAST)) begin
                            done  <= 1'b1;
                            state <= FIN;
                        end else begin
                            addr  <= addr + 1'b1;
                            we    <= 1'b0;
                            req   <= 1'b1;
                            state <= XFER;
                        end
                    end
                end
                default: begin
                    if (!start) begin
                        done  <= 1'b0;
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_25_vga) begin
        if (state == XFER && ack && !we) begin
            wdata <= {gray_val, gray_val, gray_val};
        end
    end

endmodule

//--- pixel_capture.sv
// ###################################################################
// Pixel capture: writes one streamed frame into buffer one
// ###################################################################
`timescale 1ns/1ps
`include "cam_defines.svh"

module pixel_capture (
    input  logic               clk_25_vga,
    input  logic               reset_global,
    input  logic               capture_en,
    input  logic               frame_start,
    input  logic               pix_valid,
    input  cam_pkg::pixel_t    pix_data,
    output logic               pix_ready,
    output logic               req,
    output logic               we,
    output cam_pkg::pix_addr_t addr,
    output cam_pkg::pixel_t    wdata,
    input  logic               ack,
    output logic               frame_end
);
    localparam int LAST = `CAM_FRAME_W * `CAM_FRAME_H - 1;

    logic armed;
    logic wait_low;
    logic sof;
    logic take;

    // Stalled while a write is out or its ack is still high
    assign pix_ready = !req && !wait_low;
    // frame_start marks the first pixel and travels with it
    assign sof  = frame_start && pix_valid && pix_ready;
    assign take = pix_valid && pix_ready && (armed || (frame_start && capture_en));
    assign we   = req;

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            armed     <= 1'b0;
            wait_low  <= 1'b0;
            req       <= 1'b0;
            addr      <= '0;
            frame_end <= 1'b0;
        end else begin
            frame_end <= 1'b0;
            if (sof) begin
                armed <= capture_en;
            end
            if (take) begin
                req  <= 1'b1;
                addr <= frame_start ? '0 : addr + 1'b1;
            end
            if (req && ack) begin
                req      <= 1'b0;
                wait_low <= 1'b1;
                if (addr == cam_pkg::pix_addr_t'(LAST)) begin
                    armed     <= 1'b0;
                    frame_end <= 1'b1;
                end
            end
            if (wait_low && !ack) begin
                wait_low <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_25_vga) begin
        if (take) begin
            wdata <= pix_data;
        end
    end

endmodule

//--- buf_arbiter.sv
// ###################################################################
// Buffer one arbiter: fixed priority capture, gray, edge, 4-phase acks
// ###################################################################
`timescale 1ns/1ps
`include "cam_defines.svh"

module buf_arbiter (
    input  logic               clk_25_vga,
    input  logic               reset_global,
    input  logic               cap_req,
    input  logic               cap_we,
    input  cam_pkg::pix_addr_t cap_addr,
    input  cam_pkg::pixel_t    cap_wdata,
    output logic               cap_ack,
    input  logic               gray_req,
    input  logic               gray_we,
    input  cam_pkg::pix_addr_t gray_addr,
    input  cam_pkg::pixel_t    gray_wdata,
    output logic               gray_ack,
    input  logic               edge_req,
    input  cam_pkg::pix_addr_t edge_addr,
    output logic               edge_ack,
    output cam_pkg::pixel_t    rdata,
    output logic               ram_we,
    output cam_pkg::pix_addr_t ram_addr,
    output cam_pkg::pixel_t    ram_wdata,
    input  cam_pkg::pixel_t    ram_rdata
);
    typedef enum logic [1:0] {IDLE, ACCESS, ACK, RELEASE} arb_state_t;

    arb_state_t state;
    // One-hot: bit 0 capture, bit 1 gray, bit 2 edge
    logic [2:0] grant;
    logic [2:0] reqs;
    logic       sel_we;

    assign reqs = {edge_req, gray_req, cap_req};

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            state <= IDLE;
            grant <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (|reqs) begin
                        grant <= cap_req ? 3'b001 : (gray_req ? 3'b010 : 3'b100);
                        state <= ACCESS;
                    end
                end
                ACCESS: state <= ACK;
                // ack stays up until the winner drops req
                ACK: begin
                    if (!(|(grant & reqs))) begin
                        state <= RELEASE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // RAM port follows the registered grant
    always_comb begin
        ram_addr  = cap_addr;
        ram_wdata = cap_wdata;
        sel_we    = cap_we;
        if (grant[1]) begin
            ram_addr  = gray_addr;
            ram_wdata = gray_wdata;
            sel_we    = gray_we;
        end else if (grant[2]) begin
            ram_addr = edge_addr;
            sel_we   = 1'b0;
        end
    end

    assign ram_we   = (state == ACCESS) && sel_we;
    // Read word is registered by the RAM and valid during ACK
    assign rdata    = ram_rdata;
    assign cap_ack  = (state == ACK) && grant[0];
    assign gray_ack = (state == ACK) && grant[1];
    assign edge_ack = (state == ACK) && grant[2];

    // A requester starts a new access only once its previous ack is low
    a_req_after_ack: assert property (@(posedge clk_25_vga) disable iff (reset_global)
        !(($rose(cap_req) && $past(cap_ack)) || ($rose(gray_req) && $past(gray_ack))
          || ($rose(edge_req) && $past(edge_ack))));

    a_req_held: assert property (@(posedge clk_25_vga) disable iff (reset_global)
        (state == ACCESS) |-> |(grant & reqs));

endmodule

//--- frame_ram.sv
// ###################################################################
// Frame buffer: one read/write port, one read-only display port
// ###################################################################
`timescale 1ns/1ps
`include "cam_defines.svh"

module frame_ram (
    input  logic               clk_25_vga,
    input  logic               a_we,
    input  cam_pkg::pix_addr_t a_addr,
    input  cam_pkg::pixel_t    a_wdata,
    output cam_pkg::pixel_t    a_rdata,
    input  cam_pkg::pix_addr_t b_addr,
    output cam_pkg::pixel_t    b_rdata
);
    localparam int DEPTH = `CAM_FRAME_W * `CAM_FRAME_H;

    cam_pkg::pixel_t mem [DEPTH];

    // Port A returns the old word on a write
    always_ff @(posedge clk_25_vga) begin
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
        a_rdata <= mem[a_addr];
    end

    always_ff @(posedge clk_25_vga) begin
        b_rdata <= mem[b_addr];
    end

endmodule

//--- cam_pkg.sv
// ###################################################################
// Camera path types: pixel, address, intensity and sequencer state
// ###################################################################
`include "cam_defines.svh"

package cam_pkg;

    // RGB444, red in the top nibble
    typedef logic [`CAM_PIX_W-1:0] pixel_t;

    // Linear address, row * width + column
    typedef logic [`CAM_ADDR_W-1:0] pix_addr_t;

    typedef logic [`CAM_GRAY_W-1:0] gray_t;

    // Mode of the top-level sequencer
    typedef enum logic [1:0] {
        NORMAL,
        GRAY,
        EDGE,
        SHOW
    } cam_state_t;

endpackage

//--- cam_defines.svh
// ###################################################################
// Camera path constants: frame size, raster timing and field widths
// ###################################################################
`ifndef CAM_DEFINES_SVH
`define CAM_DEFINES_SVH

// Scaled-down frame, sizes both buffers and all address counters
`define CAM_FRAME_W 16
`define CAM_FRAME_H 12
`define CAM_ADDR_W 8

// Raster totals and sync windows (syncs are active low)
`define CAM_H_TOTAL 24
`define CAM_V_TOTAL 16
`define CAM_HSYNC_START 18
`define CAM_HSYNC_END 20
`define CAM_VSYNC_START 13
`define CAM_VSYNC_END 14

// Pixel fields
`define CAM_PIX_W 12
`define CAM_GRAY_W 4

`endif
